// ==== add_bias.sv ====
`timescale 1ns/1ps

module add_bias
  import cnn_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  en,
  input  fmap_t d,
  input  bias_t b,
  output fmap_t q
);

  fmap_t biased;

  // same bias for every position of a filter
  // plain 20-bit add, overflow wraps
  always_comb begin
    for (int f = 0; f < N_FILT; f++) begin
      for (int p = 0; p < N_WIN; p++) begin
        biased[f][p] = d[f][p] + b[f];
      end
    end
  end

  // layer output register
  // loaded only in BIAS, so q is stable through FINI and idle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (en) begin
      q <= biased;
    end
  end

endmodule

// ==== cnn_layer.f ====
cnn_pkg.sv
state_calc.sv
zero_padding.sv
im2col.sv
window_ram.sv
dot.sv
add_bias.sv
cnn_layer.sv
cnn_layer_tb.sv

// ==== cnn_layer.sv ====
`timescale 1ns/1ps

module cnn_layer
  import cnn_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      load,
  input  layer_in_t d,
  output logic      valid,
  output fmap_t     q
);

  calc_state_e       cs_calc;
  logic              accept;
  logic              adv;
  layer_in_t         in_r;

  pad_img_t          zpadout;

  logic              im2c_wr;
  logic [ADDR_W-1:0] im2c_addr;
  win_t              im2cout;
  logic              im2c_done;

  logic [ADDR_W-1:0] ram_addr;
  win_t              ramout;

  logic [ADDR_W-1:0] dot_addr;
  fmap_t             dotout;
  logic              dot_done;

  // load only counts while idle
  assign accept = load && (cs_calc == CIDL);

  // input bundle held for the whole layer
  always_ff @(posedge clk) begin
    if (accept) begin
      in_r <= d;
    end
  end

  // step condition per phase
  // ZPAD and BIAS take one cycle, the others wait for done
  always_comb begin
    case (cs_calc)
      ZPAD:    adv = 1'b1;
      IM2C:    adv = im2c_done;
      DOTP:    adv = dot_done;
      BIAS:    adv = 1'b1;
      default: adv = 1'b0;
    endcase
  end

  // ram is shared, writer in IM2C, reader in DOTP
  assign ram_addr = (cs_calc == DOTP) ? dot_addr : im2c_addr;

  assign valid = (cs_calc == FINI);

  state_calc state_calc_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .run    (accept),
    .adv    (adv),
    .q      (cs_calc)
  );

  zero_padding zero_padding_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (cs_calc == ZPAD),
    .d      (in_r.img),
    .q      (zpadout)
  );

  im2col im2col_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (cs_calc == IM2C),
    .d      (zpadout),
    .wr_en  (im2c_wr),
    .addr   (im2c_addr),
    .q      (im2cout),
    .done   (im2c_done)
  );

  window_ram window_ram_inst (
    .clk    (clk),
    .we     (im2c_wr),
    .addr   (ram_addr),
    .d      (im2cout),
    .q      (ramout)
  );

  dot dot_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (cs_calc == DOTP),
    .w      (in_r.kern),
    .d      (ramout),
    .addr   (dot_addr),
    .q      (dotout),
    .done   (dot_done)
  );

  add_bias add_bias_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (cs_calc == BIAS),
    .d      (dotout),
    .b      (in_r.bias),
    .q      (q)
  );

  // a load mid-layer would be dropped silently
  assert property (@(posedge clk) disable iff (!arst_n)
    load |-> (cs_calc == CIDL))
    else $error("cnn_layer: load while busy, state %s", cs_calc.name());

endmodule

// ==== cnn_layer_cases.txt ====
# per case: name, 16 pixels (r*4+c), 18 weights (f0 then f1, i*3+j), bias0 bias1
# then 16 expected sums of filter 0 and 16 of filter 1 (r*4+c)
# all values hex two's complement, pixels and weights 8 bit, sums 20 bit
zero_img
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 01 01 01 01 01 01 01 7f 80 ff 02 fe 03 fd 04 fc
00005 ffffd
00005 00005 00005 00005 00005 00005 00005 00005 00005 00005 00005 00005 00005 00005 00005 00005
ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd ffffd
identity
01 02 03 04 05 06 07 08 f9 fa fb fc 80 7f 00 ff
00 00 00 00 01 00 00 00 00 00 00 00 00 01 00 00 00 00
00010 fff00
00011 00012 00013 00014 00015 00016 00017 00018 00009 0000a 0000b 0000c fff90 0008f 00010 0000f
fff01 fff02 fff03 fff04 fff05 fff06 fff07 fff08 ffef9 ffefa ffefb ffefc ffe80 fff7f fff00 ffeff
ones_shift
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
01 01 01 01 01 01 01 01 01 01 00 00 00 00 00 00 00 00
00000 00064
0000e 00018 0001e 00016 00021 00036 0003f 0002d 00039 0005a 00063 00045 0002e 00048 0004e 00036
00064 00064 00064 00064 00064 00065 00066 00067 00064 00069 0006a 0006b 00064 0006d 0006e 0006f
extreme
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80 80 7f 7f 7f 7f 7f 7f 7f 7f 7f
7ffff 80000
8ffff 97fff 97fff 8ffff 97fff a3fff a3fff 97fff 97fff a3fff a3fff 97fff 8ffff 97fff 97fff 8ffff
70200 68300 68300 70200 68300 5c480 5c480 68300 68300 5c480 5c480 68300 70200 68300 68300 70200
sobel
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
ff 00 01 fe 00 02 ff 00 01 00 00 00 00 00 00 00 00 ff
00000 00003
0000a 00006 00006 ffff3 00018 00008 00008 fffe4 00028 00008 00008 fffd4 00026 00006 00006 fffd7
ffffd ffffc ffffb 00003 ffff9 ffff8 ffff7 00003 ffff5 ffff4 ffff3 00003 00003 00003 00003 00003

// ==== cnn_layer_tb.sv ====
`timescale 1ns/1ps

module cnn_layer_tb
  import cnn_pkg::*;
();

  localparam int MAX_CASES   = 16;
  localparam int RST_CYCLES  = 10;
  localparam int IDLE_CYCLES = 4;
  // generous per-case budget, a layer needs about 40 cycles
  localparam int CASE_CYCLES = 100;

  logic      clk = 1'b0;
  logic      arst_n;
  logic      load;
  layer_in_t d;
  logic      valid;
  fmap_t     q;

  // seed for randomized stimulus
  int seed = 32'h3a5;

  // case table, filled from the cases file before reset ends
  logic [8*32-1:0] case_name [MAX_CASES];
  layer_in_t       case_in   [MAX_CASES];
  fmap_t           case_exp  [MAX_CASES];
  int              n_cases     = 0;
  logic            cases_ready = 1'b0;

  // counts every cycle with valid high
  int              valid_cnt   = 0;

  // 4 ns period
  always #2 clk = ~clk;

  cnn_layer dut0 (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (load),
    .d      (d),
    .valid  (valid),
    .q      (q)
  );

  always @(posedge clk) begin
    if (valid) begin
      valid_cnt <= valid_cnt + 1;
    end
  end

  task automatic check_val(input string name, input logic [ACC_W-1:0] expected,
                           input logic [ACC_W-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // first nonblank byte of a token read with %s
  function automatic logic [7:0] first_char(input logic [8*32-1:0] s);
    logic [7:0] c;
    c = 8'h00;
    for (int i = 31; i >= 0; i--) begin
      if (c == 8'h00) begin
        c = s[i*8 +: 8];
      end
    end
    return c;
  endfunction

  task automatic read_hex(input int fd, output logic [31:0] val);
    int          rc;
    logic [31:0] tok;
    tok = '0;
    rc  = $fscanf(fd, "%h", tok);
    val = tok;
    if (rc != 1) begin
      $display("cases file is malformed or ends in the middle of a case");
      $display("Simulation FAILED");
      $fatal(1, "bad cases file");
    end
  endtask

  task automatic read_cases();
    int               fd;
    int               rc;
    logic [8*32-1:0]  name;
    logic [8*128-1:0] rest;
    logic [31:0]      tok;
    bit               at_end;
    fd = $fopen("cnn_layer_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open cnn_layer_cases.txt");
      $display("Simulation FAILED");
      $fatal(1, "missing cases file");
    end
    at_end = 1'b0;
    while (!at_end) begin
      name = '0;
      rc   = $fscanf(fd, "%s", name);
      if (rc != 1) begin
        at_end = 1'b1;
      end else if (first_char(name) == "#") begin
        // comment line, drop the rest of it
        rc = $fgets(rest, fd);
      end else if (n_cases == MAX_CASES) begin
        $display("cases file holds more than %0d cases", MAX_CASES);
        $display("Simulation FAILED");
        $fatal(1, "too many cases");
      end else begin
        case_name[n_cases] = name;
        // pixels, row-major
        for (int p = 0; p < IMG_W * IMG_W; p++) begin
          read_hex(fd, tok);
          case_in[n_cases].img[p] = tok[PIX_W-1:0];
        end
        // weights, filter 0 first
        for (int f = 0; f < N_FILT; f++) begin
          for (int i = 0; i < WIN_N; i++) begin
            read_hex(fd, tok);
            case_in[n_cases].kern[f][i] = tok[PIX_W-1:0];
          end
        end
        for (int f = 0; f < N_FILT; f++) begin
          read_hex(fd, tok);
          case_in[n_cases].bias[f] = tok[ACC_W-1:0];
        end
        // expected sums, filter outer
        for (int f = 0; f < N_FILT; f++) begin
          for (int p = 0; p < N_WIN; p++) begin
            read_hex(fd, tok);
            case_exp[n_cases][f][p] = tok[ACC_W-1:0];
          end
        end
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  // one load, wait for valid, compare the map, then check pulse width and hold
  task automatic run_case(input int n);
    string tag;
    tag = $sformatf("%0s", case_name[n]);
    @(posedge clk);
    #1;
    load = 1'b1;
    d    = case_in[n];
    @(posedge clk);
    #1;
    load = 1'b0;
    // bundle must already be captured inside
    d    = '0;
    @(negedge clk);
    while (!valid) begin
      @(negedge clk);
    end
    for (int f = 0; f < N_FILT; f++) begin
      for (int p = 0; p < N_WIN; p++) begin
        check_val($sformatf("%s f%0d p%0d", tag, f, p), case_exp[n][f][p], q[f][p]);
      end
    end
    @(negedge clk);
    check_val({tag, " valid_pulse_width"}, '0, ACC_W'(valid));
    for (int f = 0; f < N_FILT; f++) begin
      for (int p = 0; p < N_WIN; p++) begin
        check_val($sformatf("%s hold f%0d p%0d", tag, f, p), case_exp[n][f][p], q[f][p]);
      end
    end
  endtask

  initial begin
    arst_n = 1'b0;
    load   = 1'b0;
    d      = '0;
    read_cases();
    if (n_cases == 0) begin
      $display("cases file holds no cases");
      $display("Simulation FAILED");
      $fatal(1, "empty cases file");
    end
    cases_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // nothing loaded yet, valid stays low
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      check_val("idle_valid", '0, ACC_W'(valid));
    end
    for (int n = 0; n < n_cases; n++) begin
      run_case(n);
    end
    // exactly one valid cycle per load
    check_val("valid_pulse_count", ACC_W'(n_cases), ACC_W'(valid_cnt));
    $display("Simulation PASSED");
    $finish;
  end

  // watchdog
  initial begin
    wait (cases_ready);
    repeat (n_cases * CASE_CYCLES + RST_CYCLES + IDLE_CYCLES) @(posedge clk);
    $display("valid never arrived before the watchdog expired");
    $display("Simulation FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

// ==== cnn_pkg.sv ====
package cnn_pkg;

  // image geometry
  // 4x4 input, one pixel of zero border on each side
  localparam int IMG_W  = 4;
  localparam int PAD_W  = 6;

  // 3x3 kernel, stride 1
  localparam int K_W    = 3;
  localparam int WIN_N  = 9;

  // one window per output position
  localparam int N_WIN  = 16;
  localparam int N_FILT = 2;

  // window ram address, indexes N_WIN words
  localparam int ADDR_W = 4;

  // data widths
  localparam int PIX_W  = 8;
  // 9 products of 8x8 bits plus bias, with headroom
  localparam int ACC_W  = 20;

  // single pixel or weight
  typedef logic signed [PIX_W-1:0] pix_t;

  // accumulated sum, wraps at 20 bits
  typedef logic signed [ACC_W-1:0] acc_t;

  // raw input image, row-major, index r*IMG_W+c
  typedef pix_t [IMG_W*IMG_W-1:0] img_t;

  // zero padded image, row-major, index r*PAD_W+c
  typedef pix_t [PAD_W*PAD_W-1:0] pad_img_t;

  // one 3x3 patch, row-major, index i*K_W+j
  typedef pix_t [WIN_N-1:0] win_t;

  // one kernel per filter, same layout as a window
  typedef win_t [N_FILT-1:0] kern_t;

  // one bias per filter
  typedef acc_t [N_FILT-1:0] bias_t;

  // feature map, filter outer, output position row-major inside
  typedef acc_t [N_FILT-1:0][N_WIN-1:0] fmap_t;

  // everything taken in on load
  typedef struct packed {
    img_t  img;
    kern_t kern;
    bias_t bias;
  } layer_in_t;

  // layer phases
  typedef enum logic [2:0] {
    CIDL,
    ZPAD,
    IM2C,
    DOTP,
    BIAS,
    FINI
  } calc_state_e;

endpackage

// ==== dot.sv ====
`timescale 1ns/1ps

module dot
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              en,
  input  kern_t             w,
  input  win_t              d,
  output logic [ADDR_W-1:0] addr,
  output fmap_t             q,
  output logic              done
);

  // cycle count within DOTP
  // 0..15 issue addresses, 1..16 have read data back
  logic [ADDR_W:0]   cnt;
  logic              rd_vld;
  logic [ADDR_W-1:0] wr_idx;
  bias_t             sum;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (en) begin
      cnt <= cnt + 1'b1;
    end else begin
      cnt <= '0;
    end
  end

  // address issued this cycle, the extra read in cycle 16 is ignored
  assign addr   = cnt[ADDR_W-1:0];

  // data on d belongs to the address issued one cycle earlier
  assign rd_vld = en && (cnt != '0);
  assign wr_idx = ADDR_W'(cnt - 1'b1);

  // last window's data arrives in the 17th cycle
  assign done   = (cnt == (ADDR_W + 1)'(N_WIN));

  // both filters at once
  // 9 signed products each, summed in 20 bits
  always_comb begin
    for (int f = 0; f < N_FILT; f++) begin
      sum[f] = '0;
      for (int i = 0; i < WIN_N; i++) begin
        sum[f] = sum[f] + acc_t'(d[i]) * acc_t'(w[f][i]);
      end
    end
  end

  // store at the delayed address
  // map holds until the next layer overwrites it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (rd_vld) begin
      for (int f = 0; f < N_FILT; f++) begin
        q[f][wr_idx] <= sum[f];
      end
    end
  end

  // done is decoded from the count alone,
  // so it relies on the sequencer leaving DOTP on it
  assert property (@(posedge clk) disable iff (!arst_n)
    done |-> en)
    else $error("dot: done raised outside the DOTP phase");

endmodule

// ==== im2col.sv ====
`timescale 1ns/1ps

module im2col
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              en,
  input  pad_img_t          d,
  output logic              wr_en,
  output logic [ADDR_W-1:0] addr,
  output win_t              q,
  output logic              done
);

  // window origin in the padded frame
  // also the output position, since stride is 1
  logic [1:0] row;
  logic [1:0] col;

  // row-major walk over the 4x4 origins
  // cleared whenever the phase is not active
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      row <= '0;
      col <= '0;
    end else if (!en) begin
      row <= '0;
      col <= '0;
    end else begin
      col <= col + 2'd1;
      if (col == 2'(IMG_W - 1)) begin
        row <= row + 2'd1;
      end
    end
  end

  // cut the 3x3 patch at the current origin
  always_comb begin
    for (int i = 0; i < K_W; i++) begin
      for (int j = 0; j < K_W; j++) begin
        q[i * K_W + j] = d[(int'(row) + i) * PAD_W + int'(col) + j];
      end
    end
  end

  // row*4+col, which is just the two counters side by side
  assign addr  = {row, col};

  // one window written per active cycle
  assign wr_en = en;

  // last origin reached
  assign done  = en && (row == 2'(IMG_W - 1)) && (col == 2'(IMG_W - 1));

  // sequencer must drop en right after the last window,
  // otherwise the counter wraps and overwrites window 0
  assert property (@(posedge clk) disable iff (!arst_n)
    (en && addr == ADDR_W'(N_WIN - 1)) |=> !en)
    else $error("im2col: window counter ran past the last window");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module cnn_layer_tb -f cnn_layer.f

./obj_dir/Vcnn_layer_tb | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
  echo "cnn_layer: run passed"
else
  echo "cnn_layer: run failed, see sim.log"
  exit 1
fi

// ==== state_calc.sv ====
`timescale 1ns/1ps

module state_calc
  import cnn_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        run,
  input  logic        adv,
  output calc_state_e q
);

  calc_state_e state_nxt;

  // phase order is fixed
  // idle waits for run, the work phases wait for adv
  always_comb begin
    state_nxt = q;
    case (q)
      CIDL: begin
        if (run) begin
          state_nxt = ZPAD;
        end
      end
      ZPAD: begin
        if (adv) begin
          state_nxt = IM2C;
        end
      end
      IM2C: begin
        if (adv) begin
          state_nxt = DOTP;
        end
      end
      DOTP: begin
        if (adv) begin
          state_nxt = BIAS;
        end
      end
      BIAS: begin
        if (adv) begin
          state_nxt = FINI;
        end
      end
      // result shown for one cycle only
      FINI: begin
        state_nxt = CIDL;
      end
      // unused codes fall back to idle
      default: begin
        state_nxt = CIDL;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= CIDL;
    end else begin
      q <= state_nxt;
    end
  end

  // the two spare 3-bit codes must never be reached
  assert property (@(posedge clk) disable iff (!arst_n)
    q inside {CIDL, ZPAD, IM2C, DOTP, BIAS, FINI})
    else $error("state_calc: illegal state code %0d", q);

endmodule

// ==== window_ram.sv ====
`timescale 1ns/1ps

module window_ram
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  win_t              d,
  output win_t              q
);

  // one 72-bit word per output position
  win_t mem [N_WIN];

  // write side, filled during IM2C
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= d;
    end
  end

  // read side, one cycle latency
  // read and write phases never overlap
  always_ff @(posedge clk) begin
    q <= mem[addr];
  end

endmodule

// ==== zero_padding.sv ====
`timescale 1ns/1ps

module zero_padding
  import cnn_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     en,
  input  img_t     d,
  output pad_img_t q
);

  pad_img_t pad;

  // build the 6x6 frame
  // border stays zero, image goes one row down and one column in
  always_comb begin
    pad = '0;
    for (int r = 0; r < IMG_W; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        pad[(r + 1) * PAD_W + (c + 1)] = d[r * IMG_W + c];
      end
    end
  end

  // captured once per layer, in the single ZPAD cycle
  // held through IM2C while the windows are cut out
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (en) begin
      q <= pad;
    end
  end

endmodule
